//--- tb.f
verilog/fetch_pkg.sv
verilog/inst_mem.sv
verilog/branch_predictor.sv
verilog/fetch_stage.sv
verilog/inst_buffer.sv
verilog/fetch_top.sv
test/fetch_tb.sv

//--- test/fetch_tb.sv
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();

    localparam int reset_cycles   = 16;
    localparam int prog1_count    = 11;
    localparam int prog2_count    = 8;
    localparam int expected_total = prog1_count + prog2_count;
    localparam int timeout_cycles = reset_cycles + 40 * expected_total;

    logic                    clock;
    logic                    reset;
    logic                    load_valid;
    logic [mem_idx_bits-1:0] load_index;
    inst_t                   load_word;
    logic                    redirect_valid;
    addr_t                   redirect_pc;
    logic                    update_valid;
    addr_t                   update_pc;
    logic                    update_taken;
    addr_t                   update_target;
    logic                    pop;
    logic                    out_valid;
    addr_t                   out_pc;
    inst_t                   out_inst;

    // Program image shared by the load port and the model
    inst_t model_mem [mem_words];

    // Model predictor state
    int         model_cnt        [bp_entries];
    bit         model_btb_valid  [bp_entries];
    logic [25:0] model_btb_tag   [bp_entries];
    addr_t      model_btb_target [bp_entries];

    addr_t model_pc;
    bit    parked;
    addr_t exp_pc   [$];
    inst_t exp_inst [$];

    int errors;
    int checked;
    int seed;
    int rnd;
    int guard;
    int train_idx;
    bit hold_pop;

    fetch_top u_dut (
        .clock, .reset, .load_valid, .load_index, .load_word,
        .redirect_valid, .redirect_pc,
        .update_valid, .update_pc, .update_taken, .update_target,
        .pop, .out_valid, .out_pc, .out_inst
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic inst_t enc_addi(logic [4:0] rd, logic [11:0] imm);
        return {imm, 5'd0, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic inst_t enc_jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opcode_jal};
    endfunction

    function automatic inst_t enc_beq(logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, 5'd0, 3'b000, off[4:1], off[11], opcode_branch};
    endfunction

    function automatic bit is_transfer(inst_t inst);
        return inst[6:0] == opcode_branch || inst[6:0] == opcode_jal ||
               inst[6:0] == opcode_jalr;
    endfunction

    // Bimodal counter plus tagged BTB lookup
    function automatic void predict(input addr_t pc, output bit taken, output addr_t target);
        int idx;
        bit hit;
        idx = pc[5:2];
        hit = model_btb_valid[idx] && model_btb_tag[idx] == pc[31:6];
        taken = hit && model_cnt[idx] >= 2;
        target = hit ? model_btb_target[idx] : pc + 32'd4;
    endfunction

    // Builds one trimmed fetch group and returns 0 once fetch is parked on itself
    function automatic bit next_expected();
        addr_t base;
        addr_t slot_pc;
        addr_t npc;
        addr_t pred_target;
        inst_t w [4];
        inst_t fi;
        int    first;
        int    second;
        int    start;
        int    pushed;
        bit    taken;
        bit    is_j;
        bit    pred_taken;
        bit    progress;
        base = {model_pc[31:3], 3'b000};
        start = model_pc[2] ? 1 : 0;
        first = -1;
        second = -1;
        taken = 1'b0;
        is_j = 1'b0;
        pushed = 0;
        npc = base + 32'd16;
        for (int i = 0; i < 4; i++) begin
            w[i] = model_mem[(int'(base[9:2]) + i) % mem_words];
            if (i >= start && is_transfer(w[i])) begin
                if (first < 0) begin
                    first = i;
                end else if (second < 0) begin
                    second = i;
                end
            end
        end
        if (first >= 0) begin
            fi = w[first];
            slot_pc = base + 4 * first;
            if (fi[6:0] == opcode_jal) begin
                taken = 1'b1;
                is_j = fi[11:7] == 5'd0;
                npc = slot_pc + {{12{fi[31]}}, fi[19:12], fi[20], fi[30:21], 1'b0};
            end else begin
                predict(slot_pc, pred_taken, pred_target);
                // JALR always leaves the group
                taken = pred_taken || fi[6:0] == opcode_jalr;
                if (taken) begin
                    npc = pred_target;
                end else if (second >= 0) begin
                    npc = base + 4 * second;
                end
            end
        end
        for (int i = start; i < 4; i++) begin
            if (!(taken && i > first) && !(is_j && i == first) &&
                !(second >= 0 && i >= second)) begin
                exp_pc.push_back(base + 4 * i);
                exp_inst.push_back(w[i]);
                pushed++;
            end
        end
        progress = !(pushed == 0 && npc == model_pc);
        model_pc = npc;
        return progress;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, expected);
        end
    endtask

    // Compare popped entries, then mirror training and redirects in the model
    always @(posedge clock) begin
        if (!reset) begin
            if (out_valid && pop) begin
                guard = 0;
                while (exp_pc.size() == 0 && !parked && guard < 64) begin
                    parked = !next_expected();
                    guard++;
                end
                if (exp_pc.size() == 0) begin
                    errors++;
                    $display("Instruction at pc %h came out with nothing left to expect", out_pc);
                end else begin
                    compare_value("out_pc", out_pc, exp_pc.pop_front());
                    compare_value("out_inst", out_inst, exp_inst.pop_front());
                    checked++;
                end
            end
            if (update_valid) begin
                train_idx = update_pc[5:2];
                if (update_taken) begin
                    model_cnt[train_idx] = (model_cnt[train_idx] < 3) ?
                                           model_cnt[train_idx] + 1 : 3;
                    model_btb_valid[train_idx] = 1'b1;
                    model_btb_tag[train_idx] = update_pc[31:6];
                    model_btb_target[train_idx] = update_target;
                end else if (model_cnt[train_idx] > 0) begin
                    model_cnt[train_idx] = model_cnt[train_idx] - 1;
                end
            end
            if (redirect_valid) begin
                exp_pc.delete();
                exp_inst.delete();
                model_pc = redirect_pc;
                parked = 1'b0;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
        rnd = $random(seed);
        pop = hold_pop ? 1'b0 : rnd[0];
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge clock);
        $display("Timeout after %0d cycles, the expected instructions never all arrived",
                 timeout_cycles);
        $display("Checked %0d instructions, %0d errors", checked, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seed = 88064;
        errors = 0;
        checked = 0;
        hold_pop = 1'b0;
        model_pc = '0;
        parked = 1'b0;
        reset = 1'b1;
        load_valid = 1'b0;
        load_index = '0;
        load_word = '0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        update_valid = 1'b0;
        update_pc = '0;
        update_taken = 1'b0;
        update_target = '0;
        pop = 1'b0;
        for (int i = 0; i < bp_entries; i++) begin
            model_cnt[i] = 1;
            model_btb_valid[i] = 1'b0;
        end
        // Filler words differ by address and control transfers go on top
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i] = enc_addi(5'd1, 12'(i));
        end
        model_mem[5]  = enc_jal(5'd1, 21'd8);
        model_mem[8]  = enc_jal(5'd0, 21'd8);
        model_mem[10] = enc_beq(5'd2, 13'd16);
        model_mem[12] = enc_beq(5'd3, 13'd16);
        model_mem[14] = enc_jal(5'd0, 21'd0);
        model_mem[20] = enc_beq(5'd4, 13'd24);
        model_mem[30] = enc_jal(5'd0, 21'd0);

        load_valid = 1'b1;
        for (int i = 0; i < reset_cycles; i++) begin
            load_index = mem_idx_bits'(i);
            load_word = model_mem[i];
            next_cycle();
        end
        reset = 1'b0;

        // Second program loads while the first runs and the branch at 0x50 is trained
        for (int i = 16; i < 32; i++) begin
            load_index = mem_idx_bits'(i);
            load_word = model_mem[i];
            update_valid = i < 18;
            update_pc = 32'h50;
            update_taken = 1'b1;
            update_target = 32'h68;
            next_cycle();
        end
        load_valid = 1'b0;
        update_valid = 1'b0;
        while (checked < prog1_count) begin
            next_cycle();
        end
        repeat (20) next_cycle();

        // Fill the buffer from the second program, then flush it with a second redirect
        hold_pop = 1'b1;
        pop = 1'b0;
        redirect_valid = 1'b1;
        redirect_pc = 32'h44;
        next_cycle();
        redirect_valid = 1'b0;
        repeat (12) next_cycle();
        redirect_valid = 1'b1;
        next_cycle();
        redirect_valid = 1'b0;
        hold_pop = 1'b0;
        while (checked < expected_total) begin
            next_cycle();
        end
        repeat (20) next_cycle();

        // Buffer drained with fetch parked on the last J
        compare_value("out_valid", 32'(out_valid), 32'd0);
        $display("Checked %0d instructions, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    load_valid,
    input  logic [mem_idx_bits-1:0] load_index,
    input  inst_t                   load_word,
    input  logic                    redirect_valid,
    input  addr_t                   redirect_pc,
    input  logic                    update_valid,
    input  addr_t                   update_pc,
    input  logic                    update_taken,
    input  addr_t                   update_target,
    input  logic                    pop,
    output logic                    out_valid,
    output addr_t                   out_pc,
    output inst_t                   out_inst
);

    addr_t       line_addr0;
    addr_t       line_addr1;
    line_t       line0;
    line_t       line1;
    logic        bp_req_valid;
    addr_t       bp_req_pc;
    logic        bp_taken;
    addr_t       bp_target;
    logic  [3:0] enq_valid;
    addr_t [3:0] enq_pc;
    inst_t [3:0] enq_inst;
    slot_cnt_t   free_slots;

    inst_mem u_mem (
        .clock, .load_valid, .load_index, .load_word,
        .line_addr0, .line_addr1, .line0, .line1
    );

    branch_predictor u_bp (
        .clock, .reset, .bp_req_valid, .bp_req_pc,
        .update_valid, .update_pc, .update_taken, .update_target,
        .bp_taken, .bp_target
    );

    fetch_stage u_fetch (
        .clock, .reset, .line0, .line1, .bp_taken, .bp_target,
        .redirect_valid, .redirect_pc, .free_slots,
        .line_addr0, .line_addr1, .bp_req_valid, .bp_req_pc,
        .enq_valid, .enq_pc, .enq_inst
    );

    // A redirect empties the buffer at the same edge
    inst_buffer u_ib (
        .clock, .reset, .flush(redirect_valid),
        .enq_valid, .enq_pc, .enq_inst, .pop,
        .free_slots, .out_valid, .out_pc, .out_inst
    );

endmodule

`default_nettype wire

//--- verilog/inst_buffer.sv
`default_nettype none

module inst_buffer
    import fetch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            flush,
    input  logic      [3:0] enq_valid,
    input  addr_t     [3:0] enq_pc,
    input  inst_t     [3:0] enq_inst,
    input  logic            pop,
    output slot_cnt_t       free_slots,
    output logic            out_valid,
    output addr_t           out_pc,
    output inst_t           out_inst
);

    addr_t buf_pc   [ib_depth];
    inst_t buf_inst [ib_depth];

    logic [ib_idx_bits-1:0] head;
    logic [ib_idx_bits-1:0] tail;
    slot_cnt_t              count;

    logic [ib_idx_bits-1:0] slot_pos [4];
    slot_cnt_t              enq_num;
    logic                   pop_fire;

    assign free_slots = slot_cnt_t'(ib_depth) - count;
    assign out_valid  = count != '0;
    assign out_pc     = buf_pc[head];
    assign out_inst   = buf_inst[head];
    assign pop_fire   = pop && out_valid;
    assign enq_num    = slot_cnt_t'($countones(enq_valid));

    // Pack valid slots behind the tail in slot order
    always_comb begin
        logic [ib_idx_bits-1:0] offset;
        offset = '0;
        for (int i = 0; i < 4; i++) begin
            slot_pos[i] = tail + offset;
            if (enq_valid[i]) begin
                offset = offset + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < 4; i++) begin
            if (enq_valid[i]) begin
                buf_pc[slot_pos[i]]   <= enq_pc[i];
                buf_inst[slot_pos[i]] <= enq_inst[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ib_idx_bits'(pop_fire);
            tail  <= tail + ib_idx_bits'(enq_num);
            count <= count + enq_num - slot_cnt_t'(pop_fire);
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`default_nettype none

module fetch_stage
    import fetch_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  line_t            line0,
    input  line_t            line1,
    input  logic             bp_taken,
    input  addr_t            bp_target,
    input  logic             redirect_valid,
    input  addr_t            redirect_pc,
    input  slot_cnt_t        free_slots,
    output addr_t            line_addr0,
    output addr_t            line_addr1,
    output logic             bp_req_valid,
    output addr_t            bp_req_pc,
    output logic      [3:0]  enq_valid,
    output addr_t     [3:0]  enq_pc,
    output inst_t     [3:0]  enq_inst
);

    function automatic logic is_branch(inst_t inst);
        return inst[6:0] == opcode_branch || inst[6:0] == opcode_jal ||
               inst[6:0] == opcode_jalr;
    endfunction

    function automatic branch_cat_t classify(inst_t inst);
        case (inst[6:0])
            opcode_jal:    return (inst[11:7] == 5'd0) ? cat_j : cat_jal;
            opcode_jalr:   return cat_jalr;
            opcode_branch: return cat_branch;
            default:       return cat_none;
        endcase
    endfunction

    addr_t       pc;
    addr_t       pc_next;
    addr_t       pc_aligned;
    inst_t [3:0] insts;

    logic        first_found;
    logic        second_found;
    logic [1:0]  first_idx;
    logic [1:0]  second_idx;
    branch_cat_t first_cat;
    logic        first_taken;
    addr_t       first_pc;
    addr_t       second_pc;
    addr_t       jal_target;
    logic [3:0]  keep;
    slot_cnt_t   keep_cnt;
    logic        advance;

    assign pc_aligned = {pc[31:3], 3'b000};
    assign line_addr0 = pc_aligned;
    assign line_addr1 = pc_aligned + 32'd8;

    assign insts = {line1[63:32], line1[31:0], line0[63:32], line0[31:0]};

    // First and second control transfer at or after the PC
    always_comb begin
        first_found  = 1'b0;
        second_found = 1'b0;
        first_idx    = 2'd0;
        second_idx   = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if ((i != 0 || !pc[2]) && is_branch(insts[i])) begin
                if (!first_found) begin
                    first_found = 1'b1;
                    first_idx   = 2'(i);
                end else if (!second_found) begin
                    second_found = 1'b1;
                    second_idx   = 2'(i);
                end
            end
        end
    end

    assign first_cat = first_found ? classify(insts[first_idx]) : cat_none;
    assign first_pc  = pc_aligned + {28'd0, first_idx, 2'b00};
    assign second_pc = pc_aligned + {28'd0, second_idx, 2'b00};

    // J-immediate relative to the jump itself
    assign jal_target = first_pc + {{12{insts[first_idx][31]}}, insts[first_idx][19:12],
                                    insts[first_idx][20], insts[first_idx][30:21], 1'b0};

    // Jumps are always taken, conditional branches follow the predictor
    assign first_taken = (first_cat == cat_branch) ? bp_taken : (first_cat != cat_none);

    assign bp_req_valid = (first_cat == cat_jalr) || (first_cat == cat_branch);
    assign bp_req_pc    = first_pc;

    // Trim the group
    always_comb begin
        keep = 4'b1111;
        if (pc[2]) begin
            keep[0] = 1'b0;
        end
        for (int i = 0; i < 4; i++) begin
            if (first_taken && 2'(i) > first_idx) begin
                keep[i] = 1'b0;
            end
            if (first_cat == cat_j && 2'(i) == first_idx) begin
                keep[i] = 1'b0;
            end
            // Second branch goes out with the next group
            if (second_found && 2'(i) >= second_idx) begin
                keep[i] = 1'b0;
            end
        end
    end

    assign keep_cnt = slot_cnt_t'($countones(keep));
    assign advance  = !redirect_valid && (keep_cnt <= free_slots);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            enq_valid[i] = advance && keep[i];
            enq_pc[i]    = pc_aligned + 32'(i * 4);
            enq_inst[i]  = insts[i];
        end
    end

    always_comb begin
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (!advance) begin
            pc_next = pc;
        end else begin
            case (first_cat)
                cat_jalr:      pc_next = bp_target;
                cat_j, cat_jal: pc_next = jal_target;
                cat_branch: begin
                    if (bp_taken) begin
                        pc_next = bp_target;
                    end else if (second_found) begin
                        pc_next = second_pc;
                    end else begin
                        pc_next = pc_aligned + 32'd16;
                    end
                end
                default:       pc_next = pc_aligned + 32'd16;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/branch_predictor.sv
`default_nettype none

module branch_predictor
    import fetch_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  bp_req_valid,
    input  addr_t bp_req_pc,
    input  logic  update_valid,
    input  addr_t update_pc,
    input  logic  update_taken,
    input  addr_t update_target,
    output logic  bp_taken,
    output addr_t bp_target
);

    // Bimodal counters, 2 and above means taken
    logic [1:0] counter [bp_entries];

    // BTB, tag keeps the PC bits above the index
    logic                    btb_valid  [bp_entries];
    logic [31:bp_idx_bits+2] btb_tag    [bp_entries];
    addr_t                   btb_target [bp_entries];

    logic [bp_idx_bits-1:0] req_idx;
    logic [bp_idx_bits-1:0] upd_idx;
    logic                   btb_hit;

    assign req_idx = bp_req_pc[bp_idx_bits+1:2];
    assign upd_idx = update_pc[bp_idx_bits+1:2];

    // Lookup
    assign btb_hit   = btb_valid[req_idx] &&
                       (btb_tag[req_idx] == bp_req_pc[31:bp_idx_bits+2]);
    assign bp_taken  = bp_req_valid && counter[req_idx][1] && btb_hit;
    assign bp_target = btb_hit ? btb_target[req_idx] : bp_req_pc + 32'd4;

    // Counter training and BTB valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < bp_entries; i++) begin
                counter[i]   <= 2'd1;
                btb_valid[i] <= 1'b0;
            end
        end else if (update_valid) begin
            if (update_taken) begin
                if (counter[upd_idx] != 2'd3) begin
                    counter[upd_idx] <= counter[upd_idx] + 2'd1;
                end
                btb_valid[upd_idx] <= 1'b1;
            end else if (counter[upd_idx] != 2'd0) begin
                counter[upd_idx] <= counter[upd_idx] - 2'd1;
            end
        end
    end

    // BTB payload
    always_ff @(posedge clock) begin
        if (update_valid && update_taken) begin
            btb_tag[upd_idx]    <= update_pc[31:bp_idx_bits+2];
            btb_target[upd_idx] <= update_target;
        end
    end

endmodule

`default_nettype wire

//--- verilog/inst_mem.sv
`default_nettype none

module inst_mem
    import fetch_pkg::*;
(
    input  logic                    clock,
    input  logic                    load_valid,
    input  logic [mem_idx_bits-1:0] load_index,
    input  inst_t                   load_word,
    input  addr_t                   line_addr0,
    input  addr_t                   line_addr1,
    output line_t                   line0,
    output line_t                   line1
);

    inst_t mem [mem_words];

    // Word pair at an 8-byte boundary, index wraps at the memory depth
    function automatic line_t read_line(addr_t addr);
        logic [mem_idx_bits-1:0] base;
        base = {addr[mem_idx_bits+1:3], 1'b0};
        return {mem[base + 1'b1], mem[base]};
    endfunction

    always_ff @(posedge clock) begin
        if (load_valid) begin
            mem[load_index] <= load_word;
        end
    end

    assign line0 = read_line(line_addr0);
    assign line1 = read_line(line_addr1);

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Basic data widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // Two instructions per memory line, slot 0 in the low half
    typedef logic [63:0] line_t;

    // Instruction memory geometry
    localparam int mem_words    = 256;
    localparam int mem_idx_bits = 8;

    // Instruction buffer geometry
    localparam int ib_depth    = 8;
    localparam int ib_idx_bits = 3;

    // Holds 0 to ib_depth inclusive
    typedef logic [3:0] slot_cnt_t;

    // Predictor geometry, indexed by PC bits 5:2
    localparam int bp_entries  = 16;
    localparam int bp_idx_bits = 4;

    // RV32 control transfer opcodes
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;

    typedef enum logic [2:0] {
        cat_none   = 3'd0,
        cat_j      = 3'd1,
        cat_jal    = 3'd2,
        cat_jalr   = 3'd3,
        cat_branch = 3'd4
    } branch_cat_t;

endpackage

`default_nettype wire
